// ==== design/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] inst_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_lui
    } alu_op_t;

    // primary opcodes
    localparam logic [5:0] op_special = 6'b000000;
    localparam logic [5:0] op_beq     = 6'b000100;
    localparam logic [5:0] op_bne     = 6'b000101;
    localparam logic [5:0] op_addiu   = 6'b001001;
    localparam logic [5:0] op_andi    = 6'b001100;
    localparam logic [5:0] op_ori     = 6'b001101;
    localparam logic [5:0] op_lui     = 6'b001111;

    // function field of op_special
    localparam logic [5:0] fn_sll  = 6'b000000;
    localparam logic [5:0] fn_srl  = 6'b000010;
    localparam logic [5:0] fn_addu = 6'b100001;
    localparam logic [5:0] fn_subu = 6'b100011;
    localparam logic [5:0] fn_and  = 6'b100100;
    localparam logic [5:0] fn_or   = 6'b100101;
    localparam logic [5:0] fn_xor  = 6'b100110;
    localparam logic [5:0] fn_nor  = 6'b100111;
    localparam logic [5:0] fn_slt  = 6'b101010;
    localparam logic [5:0] fn_sltu = 6'b101011;

    localparam word_t reset_vector = 32'hbfc0_0000;

endpackage

// ==== design/regfile.sv ====
`timescale 1ns/100ps

module regfile import cpu_pkg::*; (
    input  logic      aclk,
    input  logic      aresetn,
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    output word_t     rs_data,
    output word_t     rt_data,
    input  logic      wen,
    input  reg_addr_t wreg,
    input  word_t     wdata
);

    word_t regs [32];

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wen && wreg != '0) begin
            regs[wreg] <= wdata;
        end
    end

    assign rs_data = (rs == '0) ? '0 : regs[rs];
    assign rt_data = (rt == '0) ? '0 : regs[rt];

endmodule

// ==== design/fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit import cpu_pkg::*; #(
    parameter word_t reset_pc = reset_vector
) (
    input  logic  aclk,
    input  logic  aresetn,
    output logic  inst_req,
    output word_t inst_addr,
    input  inst_t inst_rdata,
    input  logic  inst_addr_ok,
    input  logic  inst_data_ok,
    input  logic  branch_taken,
    input  word_t branch_target,
    output logic  id_valid,
    output word_t id_pc,
    output inst_t id_inst
);

    typedef enum logic {idle, wait_data} fetch_state_t;

    fetch_state_t state;
    word_t        next_addr;
    word_t        req_pc;     // address of the outstanding request
    logic         redir_pend;
    word_t        redir_pc;
    logic         slot_issued;
    logic         redir_now;
    logic         redir_later;
    word_t        redir_addr;
    logic         accept;

    // delay slot already accepted when next_addr has moved past it
    assign slot_issued = next_addr != id_pc + 32'd4;
    assign redir_now   = branch_taken && slot_issued;
    assign redir_later = redir_pend || (branch_taken && !slot_issued);
    assign redir_addr  = redir_pend ? redir_pc : branch_target;

    assign inst_req  = (state == idle) || inst_data_ok;
    assign inst_addr = redir_now ? branch_target : next_addr;
    assign accept    = inst_req && inst_addr_ok;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state      <= idle;
            next_addr  <= reset_pc;
            redir_pend <= 1'b0;
        end else begin
            if (accept)
                state <= wait_data;
            else if (inst_data_ok)
                state <= idle;

            if (accept) begin
                next_addr  <= redir_later ? redir_addr : inst_addr + 32'd4;
                redir_pend <= 1'b0; // this was the delay slot request
            end else if (redir_now) begin
                next_addr <= branch_target;
            end else if (branch_taken) begin
                redir_pend <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (branch_taken)
            redir_pc <= branch_target;
        if (accept)
            req_pc <= inst_addr;
    end

    // IF/ID register
    always_ff @(posedge aclk) begin
        if (!aresetn)
            id_valid <= 1'b0;
        else
            id_valid <= inst_data_ok; // bubble when nothing returned
    end

    always_ff @(posedge aclk) begin
        if (inst_data_ok) begin
            id_pc   <= req_pc;
            id_inst <= inst_rdata;
        end
    end

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage import cpu_pkg::*; (
    input  logic      aclk,
    input  logic      aresetn,
    input  logic      id_valid,
    input  word_t     id_pc,
    input  inst_t     id_inst,
    input  logic      fwd_ex_regwen,
    input  reg_addr_t fwd_ex_wreg,
    input  word_t     fwd_ex_data,
    input  logic      wb_regwen,
    input  reg_addr_t wb_wreg,
    input  word_t     wb_data,
    output logic      branch_taken,
    output word_t     branch_target,
    output logic      ex_valid,
    output alu_op_t   ex_alu_op,
    output word_t     ex_a,
    output word_t     ex_b,
    output logic [4:0] ex_shamt,
    output logic      ex_regwen,
    output reg_addr_t ex_wreg,
    output word_t     ex_pc
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    reg_addr_t   rs_addr, rt_addr, rd_addr;
    logic [15:0] imm;
    word_t       rs_rf, rt_rf;
    word_t       rs_val, rt_val;
    word_t       imm_ext;
    alu_op_t     alu_op;
    logic        use_imm, imm_signed, dec_regwen, is_beq, is_bne;
    reg_addr_t   dst;
    logic        regwen;

    assign opcode  = id_inst[31:26];
    assign rs_addr = id_inst[25:21];
    assign rt_addr = id_inst[20:16];
    assign rd_addr = id_inst[15:11];
    assign funct   = id_inst[5:0];
    assign imm     = id_inst[15:0];

    regfile u_regfile (
        .aclk    (aclk),
        .aresetn (aresetn),
        .rs      (rs_addr),
        .rt      (rt_addr),
        .rs_data (rs_rf),
        .rt_data (rt_rf),
        .wen     (wb_regwen),
        .wreg    (wb_wreg),
        .wdata   (wb_data)
    );

    // EX result first, then WB, then the regfile
    assign rs_val = (fwd_ex_regwen && fwd_ex_wreg == rs_addr) ? fwd_ex_data :
                    (wb_regwen && wb_wreg == rs_addr)         ? wb_data     : rs_rf;
    assign rt_val = (fwd_ex_regwen && fwd_ex_wreg == rt_addr) ? fwd_ex_data :
                    (wb_regwen && wb_wreg == rt_addr)         ? wb_data     : rt_rf;

    always_comb begin
        alu_op     = alu_add;
        use_imm    = 1'b0;
        imm_signed = 1'b0;
        dec_regwen = 1'b0;
        dst        = rd_addr;
        is_beq     = 1'b0;
        is_bne     = 1'b0;
        case (opcode)
            op_special: begin
                dec_regwen = 1'b1;
                case (funct)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_nor:  alu_op = alu_nor;
                    fn_slt:  alu_op = alu_slt;
                    fn_sltu: alu_op = alu_sltu;
                    fn_sll:  alu_op = alu_sll;
                    fn_srl:  alu_op = alu_srl;
                    default: dec_regwen = 1'b0; // unknown funct is a no-op
                endcase
            end
            op_addiu: begin
                use_imm    = 1'b1;
                imm_signed = 1'b1;
                dec_regwen = 1'b1;
                dst        = rt_addr;
            end
            op_andi, op_ori, op_lui: begin
                use_imm    = 1'b1;
                dec_regwen = 1'b1;
                dst        = rt_addr;
                alu_op     = (opcode == op_andi) ? alu_and :
                             (opcode == op_ori)  ? alu_or  : alu_lui;
            end
            op_beq: is_beq = 1'b1;
            op_bne: is_bne = 1'b1;
            default: ;
        endcase
    end

    assign imm_ext = imm_signed ? {{16{imm[15]}}, imm} : {16'b0, imm};
    assign regwen  = id_valid && dec_regwen && dst != '0; // r0 writes dropped here

    assign branch_taken  = id_valid && ((is_beq && rs_val == rt_val) ||
                                        (is_bne && rs_val != rt_val));
    assign branch_target = id_pc + 32'd4 + {{14{imm[15]}}, imm, 2'b00};

    // ID/EX register
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ex_valid  <= 1'b0;
            ex_regwen <= 1'b0;
        end else begin
            ex_valid  <= id_valid;
            ex_regwen <= regwen;
        end
    end

    always_ff @(posedge aclk) begin
        ex_alu_op <= alu_op;
        ex_a      <= rs_val;
        ex_b      <= use_imm ? imm_ext : rt_val;
        ex_shamt  <= id_inst[10:6];
        ex_wreg   <= dst;
        ex_pc     <= id_pc;
    end

endmodule

// ==== design/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage import cpu_pkg::*; (
    input  logic       aclk,
    input  logic       aresetn,
    input  logic       ex_valid,
    input  alu_op_t    ex_alu_op,
    input  word_t      ex_a,
    input  word_t      ex_b,
    input  logic [4:0] ex_shamt,
    input  logic       ex_regwen,
    input  reg_addr_t  ex_wreg,
    input  word_t      ex_pc,
    output logic       fwd_ex_regwen,
    output reg_addr_t  fwd_ex_wreg,
    output word_t      fwd_ex_data,
    output logic       wb_regwen,
    output reg_addr_t  wb_wreg,
    output word_t      wb_data,
    output word_t      wb_pc
);

    word_t alu_res;

    always_comb begin
        case (ex_alu_op)
            alu_add:  alu_res = ex_a + ex_b; // no overflow trap
            alu_sub:  alu_res = ex_a - ex_b;
            alu_and:  alu_res = ex_a & ex_b;
            alu_or:   alu_res = ex_a | ex_b;
            alu_xor:  alu_res = ex_a ^ ex_b;
            alu_nor:  alu_res = ~(ex_a | ex_b);
            alu_slt:  alu_res = {31'b0, $signed(ex_a) < $signed(ex_b)};
            alu_sltu: alu_res = {31'b0, ex_a < ex_b};
            alu_sll:  alu_res = ex_b << ex_shamt;
            alu_srl:  alu_res = ex_b >> ex_shamt;
            alu_lui:  alu_res = {ex_b[15:0], 16'b0};
            default:  alu_res = '0;
        endcase
    end

    // result goes straight back to ID
    assign fwd_ex_regwen = ex_valid && ex_regwen;
    assign fwd_ex_wreg   = ex_wreg;
    assign fwd_ex_data   = alu_res;

    // EX/WB register
    always_ff @(posedge aclk) begin
        if (!aresetn)
            wb_regwen <= 1'b0;
        else
            wb_regwen <= ex_valid && ex_regwen;
    end

    always_ff @(posedge aclk) begin
        wb_wreg <= ex_wreg;
        wb_data <= alu_res;
        wb_pc   <= ex_pc;
    end

endmodule

// ==== design/cpu_core.sv ====
`timescale 1ns/100ps

module cpu_core import cpu_pkg::*; #(
    parameter word_t reset_pc = reset_vector
) (
    input  logic       aclk,
    input  logic       aresetn,
    output logic       inst_req,
    output word_t      inst_addr,
    input  inst_t      inst_rdata,
    input  logic       inst_addr_ok,
    input  logic       inst_data_ok,
    output word_t      debug_wb_pc,
    output logic [3:0] debug_wb_rf_wen,
    output reg_addr_t  debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);

    logic       branch_taken;
    word_t      branch_target;
    logic       id_valid;
    word_t      id_pc;
    inst_t      id_inst;
    logic       ex_valid;
    alu_op_t    ex_alu_op;
    word_t      ex_a, ex_b;
    logic [4:0] ex_shamt;
    logic       ex_regwen;
    reg_addr_t  ex_wreg;
    word_t      ex_pc;
    logic       fwd_ex_regwen;
    reg_addr_t  fwd_ex_wreg;
    word_t      fwd_ex_data;
    logic       wb_regwen;
    reg_addr_t  wb_wreg;
    word_t      wb_data;
    word_t      wb_pc;

    fetch_unit #(
        .reset_pc (reset_pc)
    ) u_fetch (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .inst_req      (inst_req),
        .inst_addr     (inst_addr),
        .inst_rdata    (inst_rdata),
        .inst_addr_ok  (inst_addr_ok),
        .inst_data_ok  (inst_data_ok),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .id_valid      (id_valid),
        .id_pc         (id_pc),
        .id_inst       (id_inst)
    );

    decode_stage u_decode (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .id_valid      (id_valid),
        .id_pc         (id_pc),
        .id_inst       (id_inst),
        .fwd_ex_regwen (fwd_ex_regwen),
        .fwd_ex_wreg   (fwd_ex_wreg),
        .fwd_ex_data   (fwd_ex_data),
        .wb_regwen     (wb_regwen),
        .wb_wreg       (wb_wreg),
        .wb_data       (wb_data),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .ex_valid      (ex_valid),
        .ex_alu_op     (ex_alu_op),
        .ex_a          (ex_a),
        .ex_b          (ex_b),
        .ex_shamt      (ex_shamt),
        .ex_regwen     (ex_regwen),
        .ex_wreg       (ex_wreg),
        .ex_pc         (ex_pc)
    );

    execute_stage u_execute (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .ex_valid      (ex_valid),
        .ex_alu_op     (ex_alu_op),
        .ex_a          (ex_a),
        .ex_b          (ex_b),
        .ex_shamt      (ex_shamt),
        .ex_regwen     (ex_regwen),
        .ex_wreg       (ex_wreg),
        .ex_pc         (ex_pc),
        .fwd_ex_regwen (fwd_ex_regwen),
        .fwd_ex_wreg   (fwd_ex_wreg),
        .fwd_ex_data   (fwd_ex_data),
        .wb_regwen     (wb_regwen),
        .wb_wreg       (wb_wreg),
        .wb_data       (wb_data),
        .wb_pc         (wb_pc)
    );

    // trace mirrors the regfile write port
    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_wen   = {4{wb_regwen}};
    assign debug_wb_rf_wnum  = wb_wreg;
    assign debug_wb_rf_wdata = wb_data;

endmodule

// ==== bench/inst_mem_model.sv ====
`timescale 1ns/100ps

module inst_mem_model import cpu_pkg::*; #(
    parameter word_t base  = reset_vector,
    parameter int    words = 128,
    parameter int    seed  = 99
) (
    input  logic  aclk,
    input  logic  aresetn,
    input  logic  inst_req,
    input  word_t inst_addr,
    output inst_t inst_rdata,
    output logic  inst_addr_ok,
    output logic  inst_data_ok
);

    inst_t       mem [words];        // loaded by the testbench
    logic [31:0] rng_state = seed;
    int          acc_count = 0;      // requests taken at rising edges
    int          acc_done  = 0;
    word_t       acc_addr  = '0;
    logic        in_reset  = 1'b1;
    logic        busy;
    word_t       busy_addr;
    int          data_wait;
    int          addr_wait;

    function automatic int draw(input int span);
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return int'(rng_state[30:16]) % span;
    endfunction

    function automatic inst_t read_word(input word_t addr);
        word_t off;
        off = addr - base;
        if (off < words * 4)
            return mem[int'(off >> 2)];
        return '0; // nop outside the program
    endfunction

    // handshake seen by the DUT at this edge
    always @(posedge aclk) begin
        in_reset = !aresetn;
        if (aresetn && inst_req && inst_addr_ok) begin
            acc_addr  = inst_addr;
            acc_count = acc_count + 1;
        end
    end

    initial begin
        inst_rdata   = '0;
        inst_addr_ok = 1'b0;
        inst_data_ok = 1'b0;
        busy         = 1'b0;
        busy_addr    = '0;
        data_wait    = 0;
        addr_wait    = 0;
        forever begin
            @(negedge aclk);
            inst_data_ok = 1'b0; // one cycle pulse
            if (in_reset) begin
                inst_addr_ok = 1'b0;
                busy         = 1'b0;
                addr_wait    = draw(4);
            end else begin
                if (acc_done != acc_count) begin
                    acc_done     = acc_count;
                    inst_addr_ok = 1'b0;
                    busy         = 1'b1;
                    busy_addr    = acc_addr;
                    data_wait    = 1 + draw(3);
                    addr_wait    = draw(4);
                end
                if (busy) begin
                    data_wait = data_wait - 1;
                    if (data_wait == 0) begin
                        inst_data_ok = 1'b1;
                        inst_rdata   = read_word(busy_addr);
                        busy         = 1'b0;
                    end
                end
                // next address only once the current one is answered
                if (!busy) begin
                    if (addr_wait == 0)
                        inst_addr_ok = 1'b1;
                    else
                        addr_wait = addr_wait - 1;
                end
            end
        end
    end

endmodule

// ==== bench/tb_cpu_core.sv ====
`timescale 1ns/100ps

module tb_cpu_core import cpu_pkg::*; ();

    localparam word_t start_pc   = 32'hbfc0_0000;
    localparam int    prog_len   = 120;
    localparam int    end_idx    = prog_len - 2;   // branch-to-self
    localparam int    max_cycles = prog_len * 8 + 200;

    localparam logic [5:0] r_functs [10] = '{fn_addu, fn_subu, fn_and, fn_or, fn_xor,
                                             fn_nor, fn_slt, fn_sltu, fn_sll, fn_srl};
    localparam logic [5:0] i_ops [4] = '{op_addiu, op_ori, op_andi, op_lui};

    logic       aclk    = 1'b0;
    logic       aresetn = 1'b0;
    logic       inst_req;
    word_t      inst_addr;
    inst_t      inst_rdata;
    logic       inst_addr_ok;
    logic       inst_data_ok;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_wen;
    reg_addr_t  debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    logic [31:0] rng_state = 32'd99;
    inst_t       prog [prog_len];
    word_t       exec_pc [prog_len];   // pc of each executed instruction, in order
    int          exec_n;
    word_t       exp_pc [prog_len];
    reg_addr_t   exp_wnum [prog_len];
    word_t       exp_wdata [prog_len];
    int          exp_seq [prog_len];   // fetch number behind each write
    int          exp_n;
    int          dok_cycle [prog_len];
    int          cycle = 0;
    int          fetch_n = 0;
    int          accept_n = 0;
    int          seen_n = 0;
    int          value_errors = 0;
    int          other_errors = 0;

    initial begin
        forever #2 aclk = ~aclk;
    end

    cpu_core #(
        .reset_pc (start_pc)
    ) DUT (
        .aclk              (aclk),
        .aresetn           (aresetn),
        .inst_req          (inst_req),
        .inst_addr         (inst_addr),
        .inst_rdata        (inst_rdata),
        .inst_addr_ok      (inst_addr_ok),
        .inst_data_ok      (inst_data_ok),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    inst_mem_model #(
        .base  (start_pc),
        .words (prog_len),
        .seed  (99)
    ) imem (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .inst_rdata   (inst_rdata),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state; // callers use the upper bits
    endfunction

    function automatic reg_addr_t pick_reg();
        logic [31:0] r;
        r = next_rand();
        return {2'b00, r[31:29]}; // r0..r7 keeps forwarding busy
    endfunction

    function automatic inst_t encode_r(input logic [5:0] fn, input reg_addr_t rs,
                                       input reg_addr_t rt, input reg_addr_t rd,
                                       input logic [4:0] sh);
        return {op_special, rs, rt, rd, sh, fn};
    endfunction

    function automatic inst_t encode_i(input logic [5:0] op, input reg_addr_t rs,
                                       input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic build_program();
        logic [31:0] r;
        logic [31:0] r2;
        logic [5:0]  fn;
        logic [5:0]  op;
        reg_addr_t   rs;
        int          off;
        logic        after_branch;
        after_branch = 1'b0;
        for (int i = 0; i < end_idx; i++) begin
            r = next_rand();
            if (r[31:29] == 3'd7 && !after_branch && i <= end_idx - 2) begin
                op  = r[28] ? op_bne : op_beq;
                off = 1 + int'(r[27:26]);
                if (i + 1 + off > end_idx)
                    off = end_idx - i - 1;
                rs = pick_reg();
                prog[i] = encode_i(op, rs, r[25] ? rs : pick_reg(), 16'(off));
                after_branch = 1'b1; // delay slot must not branch
            end else if (r[31:29] < 3'd4 || r[31:29] == 3'd7) begin
                fn = r_functs[int'(r[28:25]) % 10];
                if (fn == fn_sll || fn == fn_srl)
                    prog[i] = encode_r(fn, 5'd0, pick_reg(), pick_reg(), r[24:20]);
                else
                    prog[i] = encode_r(fn, pick_reg(), pick_reg(), pick_reg(), 5'd0);
                after_branch = 1'b0;
            end else begin
                op = i_ops[r[28:27]];
                r2 = next_rand();
                prog[i] = encode_i(op, (op == op_lui) ? 5'd0 : pick_reg(), pick_reg(),
                                   r2[31:16]);
                after_branch = 1'b0;
            end
        end
        prog[end_idx]     = encode_i(op_beq, 5'd0, 5'd0, 16'hffff);
        prog[end_idx + 1] = '0;
        for (int i = 0; i < prog_len; i++)
            imem.mem[i] = prog[i];
    endtask

    // sequential ISA model with delayed branches
    task automatic run_reference();
        word_t     regs [32];
        int        pc;
        int        npc;
        int        nnpc;
        inst_t     w;
        word_t     a;
        word_t     b;
        word_t     val;
        logic      wr;
        reg_addr_t dst;
        for (int k = 0; k < 32; k++)
            regs[k] = '0;
        exec_n = 0;
        exp_n  = 0;
        pc     = 0;
        npc    = 1;
        while (pc != end_idx) begin
            w    = prog[pc];
            a    = regs[w[25:21]];
            b    = regs[w[20:16]];
            wr   = 1'b1;
            dst  = w[20:16];
            val  = '0;
            nnpc = npc + 1;
            case (w[31:26])
                op_special: begin
                    dst = w[15:11];
                    case (w[5:0])
                        fn_addu: val = a + b;
                        fn_subu: val = a - b;
                        fn_and:  val = a & b;
                        fn_or:   val = a | b;
                        fn_xor:  val = a ^ b;
                        fn_nor:  val = ~(a | b);
                        fn_slt:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        fn_sltu: val = (a < b) ? 32'd1 : 32'd0;
                        fn_sll:  val = b << w[10:6];
                        fn_srl:  val = b >> w[10:6];
                        default: wr = 1'b0;
                    endcase
                end
                op_addiu: val = a + {{16{w[15]}}, w[15:0]};
                op_andi:  val = a & {16'h0000, w[15:0]};
                op_ori:   val = a | {16'h0000, w[15:0]};
                op_lui:   val = {w[15:0], 16'h0000};
                op_beq, op_bne: begin
                    wr = 1'b0;
                    if ((a == b) == (w[31:26] == op_beq))
                        nnpc = pc + 1 + int'($signed(w[15:0]));
                end
                default: wr = 1'b0;
            endcase
            exec_pc[exec_n] = start_pc + word_t'(pc * 4);
            if (wr && dst != 5'd0) begin
                regs[dst]        = val;
                exp_pc[exp_n]    = exec_pc[exec_n];
                exp_wnum[exp_n]  = dst;
                exp_wdata[exp_n] = val;
                exp_seq[exp_n]   = exec_n;
                exp_n            = exp_n + 1;
            end
            exec_n = exec_n + 1;
            pc     = npc;
            npc    = nnpc;
        end
    endtask

    task automatic check_write();
        int k;
        if (debug_wb_rf_wen !== 4'hf) begin
            $display("Error debug_wb_rf_wen expected f got %h", debug_wb_rf_wen);
            value_errors = value_errors + 1;
        end
        if (seen_n >= exp_n) begin
            $display("register write at pc %h after the trace had ended", debug_wb_pc);
            other_errors = other_errors + 1;
        end else begin
            k = exp_seq[seen_n];
            if (debug_wb_pc !== exp_pc[seen_n]) begin
                $display("Error debug_wb_pc expected %h got %h", exp_pc[seen_n], debug_wb_pc);
                value_errors = value_errors + 1;
            end
            if (debug_wb_rf_wnum !== exp_wnum[seen_n]) begin
                $display("Error debug_wb_rf_wnum expected %h got %h",
                         exp_wnum[seen_n], debug_wb_rf_wnum);
                value_errors = value_errors + 1;
            end
            if (debug_wb_rf_wdata !== exp_wdata[seen_n]) begin
                $display("Error debug_wb_rf_wdata expected %h got %h",
                         exp_wdata[seen_n], debug_wb_rf_wdata);
                value_errors = value_errors + 1;
            end
            if (k >= fetch_n || cycle != dok_cycle[k] + 3) begin
                $display("write of pc %h did not arrive 3 cycles after its fetch returned",
                         debug_wb_pc);
                other_errors = other_errors + 1;
            end
            seen_n = seen_n + 1;
        end
    endtask

    task automatic report_and_stop();
        $display("value errors %0d, other errors %0d, writes checked %0d of %0d",
                 value_errors, other_errors, seen_n, exp_n);
        if (value_errors + other_errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    endtask

    always @(posedge aclk) begin
        if (aresetn) begin
            cycle = cycle + 1;
            if (cycle == 1) begin
                if (inst_req !== 1'b1) begin
                    $display("Error inst_req expected 1 got %h", inst_req);
                    value_errors = value_errors + 1;
                end
                if (inst_addr !== start_pc) begin
                    $display("Error inst_addr expected %h got %h", start_pc, inst_addr);
                    value_errors = value_errors + 1;
                end
                if (debug_wb_rf_wen !== 4'h0) begin
                    $display("Error debug_wb_rf_wen expected 0 got %h", debug_wb_rf_wen);
                    value_errors = value_errors + 1;
                end
            end
            if (inst_req && inst_addr_ok) begin
                if (accept_n < exec_n && inst_addr !== exec_pc[accept_n]) begin
                    $display("Error inst_addr expected %h got %h", exec_pc[accept_n], inst_addr);
                    value_errors = value_errors + 1;
                end
                accept_n = accept_n + 1;
            end
            if (inst_data_ok) begin
                if (fetch_n < prog_len)
                    dok_cycle[fetch_n] = cycle;
                fetch_n = fetch_n + 1;
            end
            if (debug_wb_rf_wen !== 4'h0)
                check_write();
            if (cycle >= max_cycles) begin
                $display("timeout, trace incomplete");
                other_errors = other_errors + 1;
                report_and_stop();
            end
        end
    end

    initial begin
        build_program();
        run_reference();
        repeat (10) @(negedge aclk);
        aresetn = 1'b1;
        while (seen_n < exp_n)
            @(negedge aclk);
        repeat (20) @(negedge aclk); // catch stray writes from the end loop
        report_and_stop();
    end

endmodule

// ==== src.f ====
design/cpu_pkg.sv
design/regfile.sv
design/fetch_unit.sv
design/decode_stage.sv
design/execute_stage.sv
design/cpu_core.sv
bench/inst_mem_model.sv
bench/tb_cpu_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the cpu_core testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_cpu_core -Mdir obj_dir \
    > build.log 2>&1 \
    && ./obj_dir/Vtb_cpu_core > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
exit 0
